// File: source/usb_rx_pkg.sv
// Shared types and sizes; FIFO depth must stay a power of two and the status byte assumes 8-bit data
`default_nettype none

package usb_rx_pkg;

	// Receive controller states, order kept from the original FSM
	typedef enum logic [3:0] {
		IDLE,
		START_RCV,
		RCV_BYTE,
		PID_WAIT,
		PID_DONE,
		RCVING,
		RCV_PULSE,
		RCV_DONE,
		CRC_CHK,
		ERROR,
		EOP_WAIT
	} rx_state_t;

	// Wishbone register map
	typedef enum logic {
		REG_DATA   = 1'b0,
		REG_STATUS = 1'b1
	} wb_reg_t;

	localparam int BYTE_W = 8;

	// Sync pattern as seen after LSB-first shifting
	localparam logic [BYTE_W-1:0] SYNC_BYTE = 8'b1000_0000;

	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = 3;

	// Remainder left by a good packet with its CRC bytes
	localparam logic [15:0] CRC_RESIDUE = 16'h800D;
	localparam logic [15:0] CRC_POLY = 16'h8005;

endpackage

`default_nettype wire

// File: source/usb_rx_shifter.sv
// Expects NRZI-decoded, unstuffed bits with one shift_enable strobe per bit time
`timescale 1ns/10ps
`default_nettype none

module usb_rx_shifter (
	input wire clk,
	input wire n_rst,
	input wire d_bit,
	input wire shift_enable,
	input wire d_edge,
	input wire receiving,
	output logic [usb_rx_pkg::BYTE_W-1:0] rx_data,
	output logic byte_received
);
	import usb_rx_pkg::*;

	logic [$clog2(BYTE_W)-1:0] bit_cnt;
	logic shift;
	logic last_bit;

	assign shift = shift_enable && receiving;
	assign last_bit = (bit_cnt == ($clog2(BYTE_W))'(BYTE_W - 1));

	// Bit count wraps at a byte boundary
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			bit_cnt <= '0;
			byte_received <= 1'b0;
		end else begin
			byte_received <= 1'b0;
			if (d_edge && !receiving) begin
				bit_cnt <= '0;
			end else if (shift) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (last_bit) begin
					byte_received <= 1'b1;
				end
			end
		end
	end

	// LSB arrives first, so new bits enter at the top
	always_ff @(posedge clk) begin
		if (shift) begin
			rx_data <= {d_bit, rx_data[BYTE_W-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: source/usb_rx_crc16.sv
// Bit-serial CRC-16 in line order; caller gates it to the bytes after the PID
`timescale 1ns/10ps
`default_nettype none

module usb_rx_crc16 (
	input wire clk,
	input wire n_rst,
	input wire d_bit,
	input wire shift_enable,
	input wire crc_enable,
	input wire crc_clear,
	output logic crc_check
);
	import usb_rx_pkg::*;

	logic [2*BYTE_W-1:0] crc;
	logic feedback;

	assign feedback = crc[2*BYTE_W-1] ^ d_bit;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			crc <= '1;
		end else if (crc_clear) begin
			crc <= '1;
		end else if (crc_enable && shift_enable) begin
			// LFSR step, taps from the generator polynomial
			if (feedback) begin
				crc <= {crc[2*BYTE_W-2:0], 1'b0} ^ CRC_POLY;
			end else begin
				crc <= {crc[2*BYTE_W-2:0], 1'b0};
			end
		end
	end

	// Data plus its inverted CRC leaves a fixed remainder
	assign crc_check = (crc == CRC_RESIDUE);

endmodule

`default_nettype wire

// File: source/usb_rx_controller.sv
// Packet FSM; EOP must land on a byte boundary and strobes must continue through SE0
`timescale 1ns/10ps
`default_nettype none

module usb_rx_controller (
	input wire clk,
	input wire n_rst,
	input wire shift_enable,
	input wire byte_received,
	input wire [usb_rx_pkg::BYTE_W-1:0] rx_data,
	input wire eop,
	input wire crc_check,
	input wire d_edge,
	output logic crc_clear,
	output logic receiving,
	output logic write_enable,
	output logic rcv_error,
	output logic crc_enable
);
	import usb_rx_pkg::*;

	rx_state_t state;
	rx_state_t next_state;
	logic write_next;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			write_enable <= 1'b0;
		end else begin
			state <= next_state;
			// Byte is written one cycle after it was flagged
			write_enable <= write_next;
		end
	end

	always_comb begin
		next_state = state;
		receiving = 1'b1;
		write_next = 1'b0;
		rcv_error = 1'b0;
		crc_enable = 1'b0;
		crc_clear = 1'b0;

		case (state)
			IDLE: begin
				receiving = 1'b0;
				crc_clear = 1'b1;
				if (d_edge) begin
					next_state = START_RCV;
				end
			end
			START_RCV: begin
				if (byte_received) begin
					next_state = RCV_BYTE;
				end
			end
			RCV_BYTE: begin
				if (rx_data == SYNC_BYTE) begin
					next_state = PID_WAIT;
				end else begin
					next_state = ERROR;
				end
			end
			PID_WAIT: begin
				if (eop) begin
					next_state = ERROR;
				end else if (byte_received) begin
					next_state = PID_DONE;
				end
			end
			PID_DONE: begin
				write_next = 1'b1;
				next_state = RCVING;
			end
			RCVING: begin
				crc_enable = 1'b1;
				// SE0 in the middle of a byte
				if (eop) begin
					next_state = ERROR;
				end else if (byte_received) begin
					next_state = RCV_PULSE;
				end
			end
			RCV_PULSE: begin
				write_next = 1'b1;
				crc_enable = 1'b1;
				next_state = RCV_DONE;
			end
			RCV_DONE: begin
				// Keep the SE0 bit out of the CRC
				crc_enable = !eop;
				if (shift_enable) begin
					if (eop) begin
						next_state = CRC_CHK;
					end else begin
						next_state = RCVING;
					end
				end
			end
			CRC_CHK: begin
				if (crc_check) begin
					next_state = EOP_WAIT;
				end else begin
					next_state = ERROR;
				end
			end
			ERROR: begin
				rcv_error = 1'b1;
				// Held until the line returns to idle
				if (d_edge) begin
					next_state = IDLE;
				end
			end
			EOP_WAIT: begin
				receiving = 1'b0;
				if (d_edge) begin
					next_state = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// Bytes arrive at least a byte time apart
	assert property (@(posedge clk) disable iff (!n_rst) write_enable |=> !write_enable)
		else $error("write_enable high twice in a row in state %s", state.name());

	assert property (@(posedge clk) disable iff (!n_rst) !(crc_enable && crc_clear))
		else $error("crc_enable and crc_clear both high in state %s", state.name());

endmodule

`default_nettype wire

// File: source/usb_rx_fifo.sv
// Receive byte FIFO; no back-pressure, writes while full are lost and flagged
`timescale 1ns/10ps
`default_nettype none

module usb_rx_fifo (
	input wire clk,
	input wire n_rst,
	input wire [usb_rx_pkg::BYTE_W-1:0] wr_data,
	input wire write_enable,
	input wire pop,
	input wire clear_overflow,
	output logic [usb_rx_pkg::BYTE_W-1:0] rd_data,
	output logic [usb_rx_pkg::FIFO_AW:0] count,
	output logic empty,
	output logic overflow
);
	import usb_rx_pkg::*;

	logic [BYTE_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic full;
	logic do_write;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign do_write = write_enable && !full;
	assign do_pop = pop && !empty;
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_write && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_write) begin
				count <= count - 1'b1;
			end
			// Set wins over a clear in the same cycle
			if (write_enable && full) begin
				overflow <= 1'b1;
			end else if (clear_overflow) begin
				overflow <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!n_rst) pop |-> !empty)
		else $error("pop issued on an empty FIFO");

endmodule

`default_nettype wire

// File: source/usb_rx_wb_slave.sv
// Wishbone classic slave, single-cycle ack; master must drop stb after ack
`timescale 1ns/10ps
`default_nettype none

module usb_rx_wb_slave (
	input wire clk,
	input wire n_rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire usb_rx_pkg::wb_reg_t wb_adr,
	input wire [usb_rx_pkg::BYTE_W-1:0] wb_dat_i,
	output logic [usb_rx_pkg::BYTE_W-1:0] wb_dat_o,
	output logic wb_ack,
	input wire [usb_rx_pkg::BYTE_W-1:0] rd_data,
	input wire [usb_rx_pkg::FIFO_AW:0] count,
	input wire empty,
	input wire overflow,
	input wire receiving,
	input wire rcv_error,
	output logic pop,
	output logic clear_overflow
);
	import usb_rx_pkg::*;

	logic req;
	logic status_wr;
	logic receiving_q;
	logic rcv_error_flag;
	logic packet_done;
	logic [BYTE_W-1:0] status;

	assign req = wb_cyc && wb_stb && !wb_ack;
	assign status_wr = req && wb_we && (wb_adr == REG_STATUS);
	assign clear_overflow = status_wr && wb_dat_i[2];
	assign status = {count, receiving, overflow, packet_done, rcv_error_flag};

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wb_ack <= 1'b0;
			pop <= 1'b0;
			receiving_q <= 1'b0;
			rcv_error_flag <= 1'b0;
			packet_done <= 1'b0;
		end else begin
			wb_ack <= req;
			// Pop lines up with the ack of a data read
			pop <= req && !wb_we && (wb_adr == REG_DATA) && !empty;
			receiving_q <= receiving;
			if (rcv_error) begin
				rcv_error_flag <= 1'b1;
			end else if (status_wr && wb_dat_i[0]) begin
				rcv_error_flag <= 1'b0;
			end
			if (receiving_q && !receiving && !rcv_error) begin
				packet_done <= 1'b1;
			end else if (status_wr && wb_dat_i[1]) begin
				packet_done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req && !wb_we) begin
			if (wb_adr == REG_STATUS) begin
				wb_dat_o <= status;
			end else begin
				wb_dat_o <= empty ? '0 : rd_data;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!n_rst) wb_ack |=> !wb_ack)
		else $error("wb_ack held for two cycles");

endmodule

`default_nettype wire

// File: source/usb_rx_top.sv
// USB full-speed receive path from decoded bits to a Wishbone-readable FIFO; no transmit side
`timescale 1ns/10ps
`default_nettype none

module usb_rx_top (
	input wire clk,
	input wire n_rst,
	input wire d_bit,
	input wire shift_enable,
	input wire eop,
	input wire d_edge,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire usb_rx_pkg::wb_reg_t wb_adr,
	input wire [usb_rx_pkg::BYTE_W-1:0] wb_dat_i,
	output logic [usb_rx_pkg::BYTE_W-1:0] wb_dat_o,
	output logic wb_ack
);
	import usb_rx_pkg::*;

	logic [BYTE_W-1:0] rx_data;
	logic [BYTE_W-1:0] rd_data;
	logic [FIFO_AW:0] count;
	logic byte_received;
	logic receiving;
	logic write_enable;
	logic rcv_error;
	logic crc_enable;
	logic crc_clear;
	logic crc_check;
	logic empty;
	logic overflow;
	logic pop;
	logic clear_overflow;

	usb_rx_shifter u_shifter (
		.clk(clk), .n_rst(n_rst), .d_bit(d_bit), .shift_enable(shift_enable),
		.d_edge(d_edge), .receiving(receiving), .rx_data(rx_data),
		.byte_received(byte_received)
	);

	usb_rx_crc16 u_crc (
		.clk(clk), .n_rst(n_rst), .d_bit(d_bit), .shift_enable(shift_enable),
		.crc_enable(crc_enable), .crc_clear(crc_clear), .crc_check(crc_check)
	);

	usb_rx_controller u_ctrl (
		.clk(clk), .n_rst(n_rst), .shift_enable(shift_enable),
		.byte_received(byte_received), .rx_data(rx_data), .eop(eop),
		.crc_check(crc_check), .d_edge(d_edge), .crc_clear(crc_clear),
		.receiving(receiving), .write_enable(write_enable), .rcv_error(rcv_error),
		.crc_enable(crc_enable)
	);

	usb_rx_fifo u_fifo (
		.clk(clk), .n_rst(n_rst), .wr_data(rx_data), .write_enable(write_enable),
		.pop(pop), .clear_overflow(clear_overflow), .rd_data(rd_data),
		.count(count), .empty(empty), .overflow(overflow)
	);

	usb_rx_wb_slave u_wb (
		.clk(clk), .n_rst(n_rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.rd_data(rd_data), .count(count), .empty(empty), .overflow(overflow),
		.receiving(receiving), .rcv_error(rcv_error), .pop(pop),
		.clear_overflow(clear_overflow)
	);

endmodule

`default_nettype wire

// File: test/tb_usb_rx_top.sv
// Feeds already decoded and unstuffed bits at one bit per four clocks
`timescale 1ns/10ps
`default_nettype none

module tb_usb_rx_top;
	import usb_rx_pkg::*;

	localparam int N_TESTS = 5;
	localparam int MAX_BYTES = 16;
	localparam int ACK_TIMEOUT = 20;
	localparam int DONE_POLLS = 40;

	// One table row: line stimulus plus the flags expected afterwards
	typedef struct packed {
		logic [BYTE_W-1:0] sync;
		logic [BYTE_W-1:0] pid;
		int n_data;
		logic crc_bad;
		int early_eop;
		logic [2:0] exp_flags;
	} test_t;

	logic clk;
	logic n_rst;
	logic d_bit;
	logic shift_enable;
	logic eop;
	logic d_edge;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_reg_t wb_adr;
	logic [BYTE_W-1:0] wb_dat_i;
	logic [BYTE_W-1:0] wb_dat_o;
	logic wb_ack;

	test_t tests [N_TESTS];
	string names [N_TESTS];
	logic [BYTE_W-1:0] pkt [MAX_BYTES];
	int pkt_len;
	int seed;
	int errors;
	int passed;

	usb_rx_top DUT (
		.clk(clk),
		.n_rst(n_rst),
		.d_bit(d_bit),
		.shift_enable(shift_enable),
		.eop(eop),
		.d_edge(d_edge),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("Error at %0t ns: %s", $time, why);
		$display("Simulation failed");
		$finish;
	endtask

	// Serial CRC-16, bits in line order, generator from CRC_POLY
	function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic b);
		logic fb;
		fb = crc[15] ^ b;
		return fb ? ({crc[14:0], 1'b0} ^ CRC_POLY) : {crc[14:0], 1'b0};
	endfunction

	function automatic logic [15:0] crc_over(input int first, input int last);
		logic [15:0] crc;
		crc = 16'hFFFF;
		for (int i = first; i <= last; i++) begin
			for (int b = 0; b < BYTE_W; b++) begin
				crc = crc_step(crc, pkt[i][b]);
			end
		end
		return crc;
	endfunction

	// Bytes after sync up to EOP, capped at the FIFO depth
	function automatic int expected_stored(input test_t t);
		int n;
		if (t.sync != SYNC_BYTE) begin
			n = 0;
		end else if (t.early_eop >= 0) begin
			n = t.early_eop / BYTE_W;
		end else begin
			n = t.n_data + 3;
		end
		return (n > FIFO_DEPTH) ? FIFO_DEPTH : n;
	endfunction

	task automatic build_packet(input test_t t);
		logic [15:0] inv;
		pkt[0] = t.sync;
		pkt[1] = t.pid;
		for (int i = 0; i < t.n_data; i++) begin
			pkt[2 + i] = BYTE_W'($random(seed));
		end
		inv = ~crc_over(2, t.n_data + 1);
		// Complemented remainder goes out high bit first
		for (int b = 0; b < BYTE_W; b++) begin
			pkt[t.n_data + 2][b] = inv[15 - b];
			pkt[t.n_data + 3][b] = inv[7 - b];
		end
		pkt_len = t.n_data + 4;
		if (crc_over(2, pkt_len - 1) != CRC_RESIDUE) begin
			$display("Error at %0t ns: reference CRC does not leave the USB residue", $time);
			errors++;
		end
		if (t.crc_bad) begin
			pkt[pkt_len - 1][0] = ~pkt[pkt_len - 1][0];
		end
	endtask

	task automatic send_bit(input logic b, input logic level_eop);
		@(posedge clk);
		d_bit <= b;
		eop <= level_eop;
		shift_enable <= 1'b1;
		@(posedge clk);
		shift_enable <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// early_eop counts bits after sync, negative for none
	task automatic send_packet(input int early_eop);
		int sent;
		logic stop;
		sent = 0;
		stop = 1'b0;
		@(posedge clk);
		d_edge <= 1'b1;
		@(posedge clk);
		d_edge <= 1'b0;
		repeat (2) @(posedge clk);
		for (int i = 0; i < pkt_len && !stop; i++) begin
			for (int b = 0; b < BYTE_W && !stop; b++) begin
				if (i > 0 && sent == early_eop) begin
					stop = 1'b1;
				end else begin
					send_bit(pkt[i][b], 1'b0);
					if (i > 0) begin
						sent++;
					end
				end
			end
		end
		// SE0 for two bit times, strobes keep running
		send_bit(1'b0, 1'b1);
		send_bit(1'b0, 1'b1);
		@(posedge clk);
		eop <= 1'b0;
		d_bit <= 1'b1;
		repeat (4) @(posedge clk);
		d_edge <= 1'b1;
		@(posedge clk);
		d_edge <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic bus_access(input logic we, input wb_reg_t adr, input logic [BYTE_W-1:0] wdata,
			output logic [BYTE_W-1:0] rdata);
		int n;
		n = 0;
		rdata = '0;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_i <= wdata;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < ACK_TIMEOUT);
		if (!wb_ack) begin
			abort_run("no wb_ack came back for a Wishbone cycle");
		end else begin
			rdata = wb_dat_o;
			@(posedge clk);
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end
	endtask

	task automatic wait_packet_end();
		logic [BYTE_W-1:0] st;
		int n;
		n = 0;
		st = '0;
		while (st[1:0] == 2'b00 && n < DONE_POLLS) begin
			bus_access(1'b0, REG_STATUS, '0, st);
			n++;
		end
		if (st[1:0] == 2'b00) begin
			abort_run("packet never finished, neither packet_done nor rcv_error came up");
		end
	endtask

	task automatic check_byte(input string name, input logic [BYTE_W-1:0] got,
			input logic [BYTE_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s expected 8'h%02h, got 8'h%02h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_status(input logic [BYTE_W-1:0] got, input logic [2:0] exp_flags,
			input logic [FIFO_AW:0] exp_count);
		if (got[2:0] !== exp_flags) begin
			$display("Fail at %0t ns: wb_dat_o status flags expected 3'b%03b, got 3'b%03b",
				$time, exp_flags, got[2:0]);
			errors++;
		end
		// Line is idle again once a packet has ended
		if (got[3] !== 1'b0) begin
			$display("Fail at %0t ns: wb_dat_o status receiving expected 0, got %0b",
				$time, got[3]);
			errors++;
		end
		if (got[BYTE_W-1:4] !== exp_count) begin
			$display("Fail at %0t ns: wb_dat_o status count expected %0d, got %0d",
				$time, exp_count, got[BYTE_W-1:4]);
			errors++;
		end
	endtask

	initial begin
		logic [BYTE_W-1:0] rd;
		logic [BYTE_W-1:0] st;
		int n_store;
		int errs_before;
		seed = 32'h8a0005f8;
		errors = 0;
		passed = 0;
		n_rst <= 1'b0;
		d_bit <= 1'b1;
		shift_enable <= 1'b0;
		eop <= 1'b0;
		d_edge <= 1'b0;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= REG_DATA;
		wb_dat_i <= '0;
		// Flags are {overflow, packet_done, rcv_error}
		tests[0] = '{SYNC_BYTE, 8'hC3, 3, 1'b0, -1, 3'b010};
		tests[1] = '{8'h40, 8'hC3, 3, 1'b0, -1, 3'b011};
		tests[2] = '{SYNC_BYTE, 8'h4B, 3, 1'b1, -1, 3'b011};
		tests[3] = '{SYNC_BYTE, 8'hC3, 3, 1'b0, 4, 3'b011};
		tests[4] = '{SYNC_BYTE, 8'hC3, 7, 1'b0, -1, 3'b110};
		names[0] = "good packet";
		names[1] = "bad sync";
		names[2] = "bad CRC";
		names[3] = "early EOP";
		names[4] = "overflow";
		repeat (10) @(posedge clk);
		n_rst <= 1'b1;
		repeat (2) @(posedge clk);

		for (int t = 0; t < N_TESTS; t++) begin
			errs_before = errors;
			build_packet(tests[t]);
			send_packet(tests[t].early_eop);
			wait_packet_end();
			n_store = expected_stored(tests[t]);
			bus_access(1'b0, REG_STATUS, '0, st);
			check_status(st, tests[t].exp_flags, (FIFO_AW + 1)'(n_store));
			for (int i = 0; i < n_store; i++) begin
				bus_access(1'b0, REG_DATA, '0, rd);
				check_byte($sformatf("wb_dat_o byte %0d", i), rd, pkt[i + 1]);
			end
			// Empty FIFO reads as zero and pops nothing
			bus_access(1'b0, REG_DATA, '0, rd);
			check_byte("wb_dat_o after drain", rd, '0);
			bus_access(1'b1, REG_STATUS, 8'h07, rd);
			bus_access(1'b0, REG_STATUS, '0, st);
			check_status(st, 3'b000, '0);
			if (errors == errs_before) begin
				passed++;
			end
			$display("Test %0d %s: %s", t, names[t], (errors == errs_before) ? "passed" : "FAILED");
		end

		$display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
			N_TESTS, passed, N_TESTS - passed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: usb_rx.f
source/usb_rx_pkg.sv
source/usb_rx_shifter.sv
source/usb_rx_crc16.sv
source/usb_rx_controller.sv
source/usb_rx_fifo.sv
source/usb_rx_wb_slave.sv
source/usb_rx_top.sv
test/tb_usb_rx_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f usb_rx.f --top-module tb_usb_rx_top --Mdir obj_dir
./obj_dir/Vtb_usb_rx_top 2>&1 | tee sim.log
if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "FAIL: run ended without a result"
	exit 1
fi
echo "PASS"
